// File: Makefile
# Verilator build and run of the ring bridge testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module ring_bridge_tb -Mdir obj_dir -o ring_bridge_sim -f src.f
	./obj_dir/ring_bridge_sim | tee sim.log
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: src.f
verilog/ring_pkg.sv
verilog/bus_pkg.sv
verilog/ring_decode.sv
verilog/bus_execute.sv
verilog/reply_result.sv
verilog/device_regs.sv
verilog/ring_bridge_top.sv
verification/ring_bridge_tb.sv

// File: verification/ring_bridge_tb.sv
`timescale 1ns/100ps

module ring_bridge_tb;

  // ====================
  // Setup
  // ====================

  localparam ring_pkg::node_id_t NODE_ID = 6'd5;
  localparam int REG_WORDS = 16;
  localparam logic [31:0] REG_BASE = 32'h0000_1000;

  // Other nodes on the ring
  localparam ring_pkg::node_id_t PEER_ID = 6'd9;
  localparam ring_pkg::node_id_t FAR_ID = 6'd12;
  localparam ring_pkg::node_id_t TRAFFIC_ID = 6'd20;

  localparam int NUM_TESTS = 10;
  localparam int CYCLE_LIMIT = NUM_TESTS * 20;
  // Longest wait for a reply after the last busy slot
  localparam int REPLY_WAIT = 12;
  // Empty slots after each test so the node is released again
  localparam int SETTLE_SLOTS = 6;

  typedef enum int {ECHO, REPLY, NO_REPLY} kind_t;

  logic clk_i = 1'b0;
  logic rst_i;
  ring_pkg::packet_t net_i;
  ring_pkg::packet_t net_o;

  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int unsigned seed_ret;

  // Stimulus table, one row per test
  string name_tab [NUM_TESTS];
  kind_t kind_tab [NUM_TESTS];
  ring_pkg::packet_t in_tab [NUM_TESTS];
  ring_pkg::packet_t exp_tab [NUM_TESTS];
  // Foreign slots driven right after the test packet
  ring_pkg::packet_t side_in_tab [NUM_TESTS];
  ring_pkg::packet_t side_exp_tab [NUM_TESTS];
  int side_len_tab [NUM_TESTS];

  ring_bridge_top #(.NODE_ID(NODE_ID), .REG_WORDS(REG_WORDS)) i_dut (
    .clk_i(clk_i), .rst_i(rst_i), .net_i(net_i), .net_o(net_o)
  );

  always #2 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ====================
  // Packet helpers
  // ====================

  // Field order from MSB: rid, tid, age, err, ack, needack, we, sel, adr, dat
  function automatic ring_pkg::packet_t make_pkt(input logic [5:0] rid, input logic [5:0] tid,
      input logic [5:0] age, input logic err, input logic ack, input logic needack,
      input logic we, input logic [3:0] sel, input logic [31:0] adr, input logic [31:0] dat);
    return {rid, tid, age, err, ack, needack, we, sel, adr, dat};
  endfunction

  // Request from the peer to this node
  function automatic ring_pkg::packet_t request_pkt(input logic we, input logic needack,
      input logic [3:0] sel, input logic [31:0] adr, input logic [31:0] dat);
    return make_pkt(NODE_ID, PEER_ID, 6'd0, 1'b0, 1'b0, needack, we, sel, adr, dat);
  endfunction

  // Reply back to the peer, IDs swapped
  function automatic ring_pkg::packet_t reply_pkt(input logic err, input logic [31:0] dat);
    return make_pkt(PEER_ID, NODE_ID, 6'd0, err, 1'b1, 1'b0, 1'b0, 4'h0, 32'h0, dat);
  endfunction

  // Byte lanes with sel set take the new value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
      input logic [31:0] new_word, input logic [3:0] sel);
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        w[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return w;
  endfunction

  function automatic void set_entry(input int idx, input string name, input kind_t kind,
      input ring_pkg::packet_t pin, input ring_pkg::packet_t pexp);
    name_tab[idx] = name;
    kind_tab[idx] = kind;
    in_tab[idx] = pin;
    exp_tab[idx] = pexp;
    side_in_tab[idx] = '0;
    side_exp_tab[idx] = '0;
    side_len_tab[idx] = 0;
  endfunction

  task automatic build_table();
    ring_pkg::age_t age_a;
    ring_pkg::age_t age_b;
    logic [31:0] dat_a;
    logic [31:0] adr_a;
    logic [31:0] dat_b;
    logic [31:0] merged;
    age_a = 6'($urandom % 63);
    age_b = 6'($urandom % 63);
    dat_a = $urandom;
    adr_a = $urandom;
    dat_b = $urandom;
    merged = merge_bytes(32'hA5A5_1234, 32'h1122_3344, 4'b0101);
    // Foreign and empty traffic
    set_entry(0, "echo_foreign", ECHO,
      make_pkt(FAR_ID, 6'd3, age_a, 1'b0, 1'b0, 1'b1, 1'b1, 4'hF, adr_a, dat_a),
      make_pkt(FAR_ID, 6'd3, age_a + 6'd1, 1'b0, 1'b0, 1'b1, 1'b1, 4'hF, adr_a, dat_a));
    set_entry(1, "echo_empty", ECHO, '0, '0);
    set_entry(2, "drop_aged", ECHO,
      make_pkt(FAR_ID, 6'd3, 6'd63, 1'b0, 1'b0, 1'b0, 1'b0, 4'h3, adr_a, dat_b), '0);
    set_entry(3, "echo_age_62", ECHO,
      make_pkt(FAR_ID, 6'd7, 6'd62, 1'b0, 1'b1, 1'b0, 1'b0, 4'h1, 32'h0, dat_b),
      make_pkt(FAR_ID, 6'd7, 6'd63, 1'b0, 1'b1, 1'b0, 1'b0, 4'h1, 32'h0, dat_b));
    // Register bank accesses
    set_entry(4, "write_ack", REPLY,
      request_pkt(1'b1, 1'b1, 4'hF, REG_BASE + 32'h8, 32'hA5A5_1234), reply_pkt(1'b0, 32'h0));
    set_entry(5, "write_noack", NO_REPLY,
      request_pkt(1'b1, 1'b0, 4'b0101, REG_BASE + 32'h8, 32'h1122_3344), '0);
    set_entry(6, "read_merged", REPLY,
      request_pkt(1'b0, 1'b0, 4'hF, REG_BASE + 32'h8, 32'h0), reply_pkt(1'b0, merged));
    set_entry(7, "read_range_err", REPLY,
      request_pkt(1'b0, 1'b1, 4'hF, REG_BASE + 32'(4 * REG_WORDS), 32'h0),
      reply_pkt(1'b1, 32'h0));
    set_entry(8, "read_misaligned", REPLY,
      request_pkt(1'b0, 1'b1, 4'hF, REG_BASE + 32'h2, 32'h0), reply_pkt(1'b1, 32'h0));
    // Reply has to wait behind a run of foreign slots
    set_entry(9, "reply_behind_traffic", REPLY,
      request_pkt(1'b0, 1'b1, 4'hF, REG_BASE + 32'h8, 32'h0), reply_pkt(1'b0, merged));
    side_in_tab[9] = make_pkt(TRAFFIC_ID, 6'd2, age_b, 1'b0, 1'b0, 1'b0, 1'b1, 4'hC, adr_a,
      dat_a);
    side_exp_tab[9] = make_pkt(TRAFFIC_ID, 6'd2, age_b + 6'd1, 1'b0, 1'b0, 1'b0, 1'b1, 4'hC,
      adr_a, dat_a);
    side_len_tab[9] = 10;
  endtask

  // ====================
  // Checks and test runner
  // ====================

  task automatic check_slot(input string test, input ring_pkg::packet_t expected);
    assert (net_o == expected) else begin
      $display("CHECK FAILED %s: expected %h actual %h", test, expected, net_o);
      error_count++;
    end
  endtask

  task automatic run_test(input int idx);
    int errors_before;
    int k;
    bit found;
    errors_before = error_count;
    found = 1'b0;
    @(posedge clk_i);
    net_i <= in_tab[idx];
    // Output of slot k shows at the falling edge after slot k+1 is driven
    for (k = 0; k <= side_len_tab[idx]; k++) begin
      @(posedge clk_i);
      net_i <= (k < side_len_tab[idx]) ? side_in_tab[idx] : '0;
      @(negedge clk_i);
      if (k == 0) begin
        // Accepted requests leave an empty slot
        check_slot(name_tab[idx], (kind_tab[idx] == ECHO) ? exp_tab[idx] : '0);
      end else begin
        check_slot(name_tab[idx], side_exp_tab[idx]);
      end
    end
    if (kind_tab[idx] == REPLY) begin
      k = 0;
      while (!found && k < REPLY_WAIT) begin
        @(negedge clk_i);
        found = (net_o != '0);
        k++;
      end
      assert (found) else begin
        $display("Test %s: no reply came back on the ring within %0d cycles", name_tab[idx],
          REPLY_WAIT);
        error_count++;
      end
      if (found) begin
        check_slot(name_tab[idx], exp_tab[idx]);
      end
    end else if (kind_tab[idx] == NO_REPLY) begin
      // Ring must stay empty for the whole reply window
      for (k = 0; k < REPLY_WAIT; k++) begin
        @(negedge clk_i);
        check_slot(name_tab[idx], '0);
      end
    end
    // No stray or repeated reply
    for (k = 0; k < SETTLE_SLOTS; k++) begin
      @(negedge clk_i);
      check_slot(name_tab[idx], '0);
    end
    if (error_count == errors_before) begin
      $display("PASS %s", name_tab[idx]);
      pass_count++;
    end else begin
      $display("FAIL %s", name_tab[idx]);
      fail_count++;
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    rst_i = 1'b1;
    net_i = '0;
    seed_ret = $urandom(32'hcc154655);
    build_table();
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors", NUM_TESTS,
      pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/bus_execute.sv
`timescale 1ns/100ps

module bus_execute (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               cmd_req_i,
  output logic               cmd_ack_o,
  input  logic               cmd_we_i,
  input  bus_pkg::bus_sel_t  cmd_sel_i,
  input  bus_pkg::bus_adr_t  cmd_adr_i,
  input  bus_pkg::bus_dat_t  cmd_dat_i,
  output logic               cyc_o,
  output logic               stb_o,
  output logic               we_o,
  output bus_pkg::bus_sel_t  sel_o,
  output bus_pkg::bus_adr_t  adr_o,
  output bus_pkg::bus_dat_t  dat_o,
  input  bus_pkg::bus_dat_t  dat_i,
  input  logic               ack_i,
  input  logic               err_i,
  output logic               res_req_o,
  input  logic               res_ack_i,
  output bus_pkg::bus_dat_t  res_dat_o,
  output logic               res_err_o
);

  typedef enum logic [1:0] {IDLE, BUS, RESULT, RELEASE} state_t;

  state_t state;

  // ====================
  // Bus master FSM
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
      cyc_o <= 1'b0;
      stb_o <= 1'b0;
      cmd_ack_o <= 1'b0;
      res_req_o <= 1'b0;
    end else begin
      // Command ack follows the request down on its own
      if (cmd_ack_o && !cmd_req_i) begin
        cmd_ack_o <= 1'b0;
      end
      case (state)
        // Start the bus cycle and acknowledge the command together
        IDLE: begin
          if (cmd_req_i && !cmd_ack_o) begin
            cyc_o <= 1'b1;
            stb_o <= 1'b1;
            cmd_ack_o <= 1'b1;
            state <= BUS;
          end
        end
        BUS: begin
          if (ack_i || err_i) begin
            cyc_o <= 1'b0;
            stb_o <= 1'b0;
            res_req_o <= 1'b1;
            state <= RESULT;
          end
        end
        // Result is offered until the reply stage has it
        RESULT: begin
          if (res_ack_i) begin
            res_req_o <= 1'b0;
            state <= RELEASE;
          end
        end
        RELEASE: begin
          if (!res_ack_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and write payload for the bus
  always_ff @(posedge clk_i) begin
    if (state == IDLE && cmd_req_i && !cmd_ack_o) begin
      we_o <= cmd_we_i;
      sel_o <= cmd_sel_i;
      adr_o <= cmd_adr_i;
      dat_o <= cmd_dat_i;
    end
  end

  // Writes and errors report zero data
  always_ff @(posedge clk_i) begin
    if (state == BUS && (ack_i || err_i)) begin
      res_dat_o <= (ack_i && !we_o) ? dat_i : '0;
      res_err_o <= err_i;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_o |-> cyc_o);

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

  // ====================
  // Register bus widths
  // ====================

  // Byte address
  typedef logic [31:0] bus_adr_t;

  // Data word in both directions
  typedef logic [31:0] bus_dat_t;

  // One enable per byte lane of the data word
  typedef logic [3:0] bus_sel_t;

  // ====================
  // Address map
  // ====================

  // First byte address of the register bank
  localparam bus_adr_t REG_BASE = 32'h0000_1000;

  // Bytes per register word, used for range checks
  localparam int WORD_BYTES = 4;

endpackage

// File: verilog/device_regs.sv
`timescale 1ns/100ps

module device_regs #(
  parameter int REG_WORDS = 16
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  bus_pkg::bus_sel_t  sel_i,
  input  bus_pkg::bus_adr_t  adr_i,
  input  bus_pkg::bus_dat_t  dat_i,
  output bus_pkg::bus_dat_t  dat_o,
  output logic               ack_o,
  output logic               err_o
);

  localparam int IDX_W = (REG_WORDS > 1) ? $clog2(REG_WORDS) : 1;
  localparam bus_pkg::bus_adr_t SPAN = bus_pkg::bus_adr_t'(bus_pkg::WORD_BYTES * REG_WORDS);

  bus_pkg::bus_dat_t regs [REG_WORDS];

  bus_pkg::bus_adr_t offset;
  logic [IDX_W-1:0] idx;
  logic access;
  logic hit;

  // New strobe only, no second response while the first is out
  assign access = cyc_i && stb_i && !ack_o && !err_o;
  assign offset = adr_i - bus_pkg::REG_BASE;
  assign idx = offset[IDX_W+1:2];
  // Word aligned and inside the bank
  assign hit = (adr_i >= bus_pkg::REG_BASE) && (offset < SPAN) && (adr_i[1:0] == 2'b00);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ack_o <= access && hit;
      err_o <= access && !hit;
      if (access && hit && we_i) begin
        // Byte lanes written one by one
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) begin
            regs[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // Read data valid alongside ack
  always_ff @(posedge clk_i) begin
    if (access && hit && !we_i) begin
      dat_o <= regs[idx];
    end
  end

endmodule

// File: verilog/reply_result.sv
`timescale 1ns/100ps

module reply_result (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                res_req_i,
  output logic                res_ack_o,
  input  bus_pkg::bus_dat_t   res_dat_i,
  input  logic                res_err_i,
  input  ring_pkg::node_id_t  meta_src_i,
  input  ring_pkg::node_id_t  meta_dst_i,
  input  logic                meta_needack_i,
  output logic                rpl_req_o,
  output ring_pkg::packet_t   rpl_pkt_o,
  input  logic                rpl_ack_i,
  output logic                txn_done_o
);

  typedef enum logic [1:0] {IDLE, HOLD, SEND, CLOSE} state_t;

  state_t state;
  ring_pkg::packet_t reply_pkt;

  // ====================
  // Reply format
  // ====================

  // IDs swapped, our own ID was the request destination
  always_comb begin
    reply_pkt = '0;
    reply_pkt[ring_pkg::RID_LSB +: ring_pkg::NODE_WID] = meta_src_i;
    reply_pkt[ring_pkg::TID_LSB +: ring_pkg::NODE_WID] = meta_dst_i;
    reply_pkt[ring_pkg::ACK_BIT] = 1'b1;
    reply_pkt[ring_pkg::ERR_BIT] = res_err_i;
    // Data is already zero for writes
    reply_pkt[ring_pkg::DATA_LSB +: ring_pkg::DATA_WID] = res_dat_i;
  end

  // Packet held fixed for the whole reply handshake
  always_ff @(posedge clk_i) begin
    if (state == IDLE && res_req_i && !res_ack_o) begin
      rpl_pkt_o <= reply_pkt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
      res_ack_o <= 1'b0;
      rpl_req_o <= 1'b0;
      txn_done_o <= 1'b0;
    end else begin
      // Single cycle release pulse
      txn_done_o <= 1'b0;
      case (state)
        IDLE: begin
          if (res_req_i && !res_ack_o) begin
            res_ack_o <= 1'b1;
            state <= HOLD;
          end
        end
        // Close the result handshake, then send or just release
        HOLD: begin
          if (!res_req_i) begin
            res_ack_o <= 1'b0;
            if (meta_needack_i) begin
              rpl_req_o <= 1'b1;
              state <= SEND;
            end else begin
              txn_done_o <= 1'b1;
              state <= IDLE;
            end
          end
        end
        SEND: begin
          if (rpl_ack_i) begin
            rpl_req_o <= 1'b0;
            state <= CLOSE;
          end
        end
        CLOSE: begin
          if (!rpl_ack_i) begin
            txn_done_o <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_rpl_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rpl_req_o && $past(rpl_req_o) |-> $stable(rpl_pkt_o));

endmodule

// File: verilog/ring_bridge_top.sv
`timescale 1ns/100ps

module ring_bridge_top #(
  parameter ring_pkg::node_id_t NODE_ID = 6'd5,
  parameter int REG_WORDS = 16
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ring_pkg::packet_t  net_i,
  output ring_pkg::packet_t  net_o
);

  // ====================
  // Stage handshakes
  // ====================

  logic cmd_req;
  logic cmd_ack;
  logic cmd_we;
  bus_pkg::bus_sel_t cmd_sel;
  bus_pkg::bus_adr_t cmd_adr;
  bus_pkg::bus_dat_t cmd_dat;
  ring_pkg::node_id_t meta_src;
  ring_pkg::node_id_t meta_dst;
  logic meta_needack;
  logic res_req;
  logic res_ack;
  bus_pkg::bus_dat_t res_dat;
  logic res_err;
  logic rpl_req;
  ring_pkg::packet_t rpl_pkt;
  logic rpl_ack;
  logic txn_done;

  // Register bus
  logic bus_cyc;
  logic bus_stb;
  logic bus_we;
  bus_pkg::bus_sel_t bus_sel;
  bus_pkg::bus_adr_t bus_adr;
  bus_pkg::bus_dat_t bus_wdat;
  bus_pkg::bus_dat_t bus_rdat;
  logic bus_ack;
  logic bus_err;

  ring_decode #(.NODE_ID(NODE_ID)) u_decode (
    .clk_i(clk_i), .rst_i(rst_i), .net_i(net_i), .net_o(net_o),
    .cmd_req_o(cmd_req), .cmd_ack_i(cmd_ack), .cmd_we_o(cmd_we),
    .cmd_sel_o(cmd_sel), .cmd_adr_o(cmd_adr), .cmd_dat_o(cmd_dat),
    .meta_src_o(meta_src), .meta_dst_o(meta_dst), .meta_needack_o(meta_needack),
    .rpl_req_i(rpl_req), .rpl_pkt_i(rpl_pkt), .rpl_ack_o(rpl_ack),
    .txn_done_i(txn_done)
  );

  bus_execute u_exec (
    .clk_i(clk_i), .rst_i(rst_i), .cmd_req_i(cmd_req), .cmd_ack_o(cmd_ack),
    .cmd_we_i(cmd_we), .cmd_sel_i(cmd_sel), .cmd_adr_i(cmd_adr), .cmd_dat_i(cmd_dat),
    .cyc_o(bus_cyc), .stb_o(bus_stb), .we_o(bus_we), .sel_o(bus_sel),
    .adr_o(bus_adr), .dat_o(bus_wdat), .dat_i(bus_rdat), .ack_i(bus_ack),
    .err_i(bus_err), .res_req_o(res_req), .res_ack_i(res_ack),
    .res_dat_o(res_dat), .res_err_o(res_err)
  );

  reply_result u_reply (
    .clk_i(clk_i), .rst_i(rst_i), .res_req_i(res_req), .res_ack_o(res_ack),
    .res_dat_i(res_dat), .res_err_i(res_err), .meta_src_i(meta_src),
    .meta_dst_i(meta_dst), .meta_needack_i(meta_needack), .rpl_req_o(rpl_req),
    .rpl_pkt_o(rpl_pkt), .rpl_ack_i(rpl_ack), .txn_done_o(txn_done)
  );

  device_regs #(.REG_WORDS(REG_WORDS)) u_regs (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we),
    .sel_i(bus_sel), .adr_i(bus_adr), .dat_i(bus_wdat), .dat_o(bus_rdat),
    .ack_o(bus_ack), .err_o(bus_err)
  );

endmodule

// File: verilog/ring_decode.sv
`timescale 1ns/100ps

module ring_decode #(
  parameter ring_pkg::node_id_t NODE_ID = 6'd5
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ring_pkg::packet_t   net_i,
  output ring_pkg::packet_t   net_o,
  output logic                cmd_req_o,
  input  logic                cmd_ack_i,
  output logic                cmd_we_o,
  output bus_pkg::bus_sel_t   cmd_sel_o,
  output bus_pkg::bus_adr_t   cmd_adr_o,
  output bus_pkg::bus_dat_t   cmd_dat_o,
  output ring_pkg::node_id_t  meta_src_o,
  output ring_pkg::node_id_t  meta_dst_o,
  output logic                meta_needack_o,
  input  logic                rpl_req_i,
  input  ring_pkg::packet_t   rpl_pkt_i,
  output logic                rpl_ack_o,
  input  logic                txn_done_i
);

  typedef enum logic [1:0] {IDLE, CMD_REQ, CMD_WAIT, BUSY} state_t;

  state_t state;

  // Destination of the slot now on the ring input
  ring_pkg::node_id_t in_rid;
  // Slot is for us and we are free to take it
  logic take;
  // Slot is empty and a reply is waiting for it
  logic insert;

  assign in_rid = net_i[ring_pkg::RID_LSB +: ring_pkg::NODE_WID];
  assign take = (state == IDLE) && (in_rid == NODE_ID);
  assign insert = rpl_req_i && !rpl_ack_o && (in_rid == '0);

  // Forwarding rule for slots this node does not consume
  function automatic ring_pkg::packet_t age_slot(input ring_pkg::packet_t p);
    ring_pkg::packet_t q;
    ring_pkg::age_t age;
    q = p;
    age = p[ring_pkg::AGE_LSB +: ring_pkg::AGE_WID];
    if (p[ring_pkg::RID_LSB +: ring_pkg::NODE_WID] == '0) begin
      // Empty slot goes round untouched
      q = p;
    end else if (age == ring_pkg::AGE_MAX) begin
      // Too old, free the slot
      q = '0;
    end else begin
      q[ring_pkg::AGE_LSB +: ring_pkg::AGE_WID] = age + 6'd1;
    end
    return q;
  endfunction

  // ====================
  // Slot output
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      net_o <= '0;
      rpl_ack_o <= 1'b0;
    end else begin
      // Release the reply acknowledge once the request is gone
      if (rpl_ack_o && !rpl_req_i) begin
        rpl_ack_o <= 1'b0;
      end
      if (take) begin
        // Remove our packet from the ring
        net_o <= '0;
      end else if (insert) begin
        net_o <= rpl_pkt_i;
        rpl_ack_o <= 1'b1;
      end else begin
        net_o <= age_slot(net_i);
      end
    end
  end

  // ====================
  // Command capture
  // ====================

  // Payload held for the bus stage and reply builder
  always_ff @(posedge clk_i) begin
    if (take) begin
      cmd_we_o <= net_i[ring_pkg::WE_BIT];
      cmd_sel_o <= net_i[ring_pkg::SEL_LSB +: ring_pkg::SEL_WID];
      cmd_adr_o <= net_i[ring_pkg::ADR_LSB +: ring_pkg::ADR_WID];
      cmd_dat_o <= net_i[ring_pkg::DATA_LSB +: ring_pkg::DATA_WID];
      meta_src_o <= net_i[ring_pkg::TID_LSB +: ring_pkg::NODE_WID];
      meta_dst_o <= in_rid;
      // Reads always answer, writes only when asked
      meta_needack_o <= net_i[ring_pkg::NEEDACK_BIT] | ~net_i[ring_pkg::WE_BIT];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
      cmd_req_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            cmd_req_o <= 1'b1;
            state <= CMD_REQ;
          end
        end
        // Hold request until the bus stage has started
        CMD_REQ: begin
          if (cmd_ack_i) begin
            cmd_req_o <= 1'b0;
            state <= CMD_WAIT;
          end
        end
        CMD_WAIT: begin
          if (!cmd_ack_i) begin
            state <= BUSY;
          end
        end
        // Our packets are echoed like foreign ones until release
        BUSY: begin
          if (txn_done_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // A new command only starts from a released node
  a_no_req_when_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cmd_req_o) |-> $past(state) != BUSY);

endmodule

// File: verilog/ring_pkg.sv
package ring_pkg;

  // ====================
  // Ring slot layout
  // ====================

  // One slot on the ring, always carried in full
  localparam int PACKET_WID = 90;
  typedef logic [PACKET_WID-1:0] packet_t;

  // Node numbers, zero means the slot is empty
  localparam int NODE_WID = 6;
  typedef logic [NODE_WID-1:0] node_id_t;

  // Hop counter carried by every packet
  localparam int AGE_WID = 6;
  typedef logic [AGE_WID-1:0] age_t;

  // A packet that has made this many hops is taken off the ring
  localparam age_t AGE_MAX = 6'd63;

  // ====================
  // Field positions
  // ====================

  // Payload data word
  localparam int DATA_LSB = 0;
  localparam int DATA_WID = 32;
  // Target address on the remote bus
  localparam int ADR_LSB = 32;
  localparam int ADR_WID = 32;
  // Byte select
  localparam int SEL_LSB = 64;
  localparam int SEL_WID = 4;

  // Single flag bits
  localparam int WE_BIT = 68;
  localparam int NEEDACK_BIT = 69;
  localparam int ACK_BIT = 70;
  localparam int ERR_BIT = 71;

  // Age, source (TID) and destination (RID)
  localparam int AGE_LSB = 72;
  localparam int TID_LSB = 78;
  localparam int RID_LSB = 84;

endpackage
